//--- fetch_frontend.f
source/fetch_pkg.sv
source/fetch_ctrl.sv
source/pc_gen.sv
source/instr_scan.sv
source/fetch_queue.sv
source/fetch_frontend.sv
tests/tb_fetch_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_fetch_frontend -f fetch_frontend.f \
    && ./obj_dir/Vtb_fetch_frontend | tee /dev/stderr | grep "Test OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/tb_fetch_frontend.sv
// directed testbench for the fetch frontend
// memory model answers every request one cycle later and never stalls
// unprogrammed words are an addi x0 pattern folded from the whole address
// expected entries follow the static rules: jal taken, backward branch taken
// the first error stops the run
`timescale 1ns/1ps

module tb_fetch_frontend import fetch_pkg::*; ();

    localparam logic [XLEN-1:0] boot_addr   = 32'h0000_0100;
    localparam int unsigned     queue_depth = 4;
    localparam int              wait_limit  = 50;

    logic            clk_i;
    logic            rst_ni;
    fetch_req_t      fetch_req;
    fetch_rsp_t      fetch_rsp;
    logic            flush;
    resolve_t        resolve;
    logic            ex_valid;
    logic [XLEN-1:0] trap_vector;
    logic            eret;
    logic [XLEN-1:0] epc;
    fetch_entry_t    entry;
    logic            entry_valid;
    logic            entry_ready;

    // programmed words: control flow and faults, with their expected scan
    logic [XLEN-1:0] prog_addr  [8];
    logic [XLEN-1:0] prog_word  [8];
    logic            prog_fault [8];
    cf_e             prog_cf    [8];
    logic [XLEN-1:0] prog_tgt   [8];
    int              prog_n = 0;

    int              seed = 22804;
    // pc of the next entry decode should see
    logic [XLEN-1:0] exp_pc;

    fetch_frontend #(
        .BootAddr   ( boot_addr   ),
        .QueueDepth ( queue_depth )
    ) fetch_frontend_i (
        .clk_i               ( clk_i       ),
        .rst_ni              ( rst_ni      ),
        .fetch_req_o         ( fetch_req   ),
        .fetch_rsp_i         ( fetch_rsp   ),
        .flush_i             ( flush       ),
        .resolve_i           ( resolve     ),
        .ex_valid_i          ( ex_valid    ),
        .trap_vector_i       ( trap_vector ),
        .eret_i              ( eret        ),
        .epc_i               ( epc         ),
        .fetch_entry_o       ( entry       ),
        .fetch_entry_valid_o ( entry_valid ),
        .fetch_entry_ready_i ( entry_ready )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        logic [11:0] fold;
        fold = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
        return {fold, 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    function automatic int lookup(input logic [XLEN-1:0] addr);
        for (int i = 0; i < prog_n; i++) begin
            if (prog_addr[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_rsp <= '0;
        end else if (fetch_req.req) begin
            fetch_rsp.valid <= 1'b1;
            fetch_rsp.data  <= (lookup(fetch_req.addr) >= 0) ?
                               prog_word[lookup(fetch_req.addr)] : fill_word(fetch_req.addr);
            fetch_rsp.fault <= (lookup(fetch_req.addr) >= 0) ?
                               prog_fault[lookup(fetch_req.addr)] : 1'b0;
        end else begin
            fetch_rsp <= '0;
        end
    end

    // ------------------------------------------------------------
    // program table
    // ------------------------------------------------------------
    task automatic program_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] word,
                                input logic fault, input cf_e cf, input logic [XLEN-1:0] tgt);
        prog_addr[prog_n]  = addr;
        prog_word[prog_n]  = word;
        prog_fault[prog_n] = fault;
        prog_cf[prog_n]    = cf;
        prog_tgt[prog_n]   = tgt;
        prog_n++;
    endtask

    // jal x1, off
    task automatic place_jal(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] off);
        program_word(addr, {off[20], off[10:1], off[11], off[19:12], 5'd1, OpJal},
                     1'b0, CF_JUMP, addr + off);
    endtask

    // beq x0, x0, off; only a backward one is predicted
    task automatic place_branch(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] off);
        logic [XLEN-1:0] word;
        word = {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], OpBranch};
        if (off[XLEN-1]) begin
            program_word(addr, word, 1'b0, CF_BRANCH, addr + off);
        end else begin
            program_word(addr, word, 1'b0, CF_NONE, addr + 32'd4);
        end
    endtask

    task automatic mark_fault(input logic [XLEN-1:0] addr);
        program_word(addr, fill_word(addr), 1'b1, CF_NONE, addr + 32'd4);
    endtask

    // ------------------------------------------------------------
    // reference model and checks
    // ------------------------------------------------------------
    function automatic fetch_entry_t expected_entry(input logic [XLEN-1:0] pc);
        fetch_entry_t e;
        int           idx;
        idx            = lookup(pc);
        e.pc           = pc;
        e.instr        = fill_word(pc);
        e.fault        = 1'b0;
        e.cf           = CF_NONE;
        e.predict_addr = pc + 32'd4;
        if (idx >= 0) begin
            e.instr        = prog_word[idx];
            e.fault        = prog_fault[idx];
            e.cf           = prog_cf[idx];
            e.predict_addr = prog_tgt[idx];
        end
        return e;
    endfunction

    // taken predictions steer, everything else is sequential
    function automatic logic [XLEN-1:0] follow_pc(input fetch_entry_t e);
        if (e.cf == CF_JUMP || e.cf == CF_BRANCH) begin
            return e.predict_addr;
        end
        return e.pc + 32'd4;
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_entry(input string name, input fetch_entry_t got,
                               input fetch_entry_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic accept_entry();
        fetch_entry_t exp;
        exp = expected_entry(exp_pc);
        check_addr("fetch_entry_o.pc", entry.pc, exp_pc);
        check_entry("fetch_entry_o", entry, exp);
        exp_pc = follow_pc(exp);
    endtask

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    // ready high, n entries, each within wait_limit cycles
    task automatic receive_entries(input int n);
        int got;
        int waited;
        got         = 0;
        waited      = 0;
        entry_ready <= 1'b1;
        while (got < n) begin
            @(posedge clk_i);
            if (entry_valid && entry_ready) begin
                accept_entry();
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited >= wait_limit) begin
                    $display("no entry accepted within %0d cycles at %0t", wait_limit, $time);
                    stop_run();
                end
            end
        end
    endtask

    task automatic receive_random(input int cycles);
        logic [31:0] rnd;
        int          got;
        got = 0;
        repeat (cycles) begin
            rnd = $random(seed);
            entry_ready <= rnd[0];
            @(posedge clk_i);
            if (entry_valid && entry_ready) begin
                accept_entry();
                got++;
            end
        end
        if (got == 0) begin
            $display("no entry accepted during %0d cycles of random ready", cycles);
            stop_run();
        end
    endtask

    // one-cycle redirect pulse followed by a check of the next request
    task automatic redirect(input logic mis, input logic [XLEN-1:0] mis_target,
                            input logic ex, input logic er);
        resolve.valid      <= mis;
        resolve.mispredict <= mis;
        resolve.target     <= mis_target;
        ex_valid           <= ex;
        eret               <= er;
        // exception, then eret, then mispredict
        if (ex) begin
            exp_pc = trap_vector;
        end else if (er) begin
            exp_pc = epc;
        end else begin
            exp_pc = mis_target;
        end
        @(posedge clk_i);
        resolve  <= '0;
        ex_valid <= 1'b0;
        eret     <= 1'b0;
        // the cycle after the redirect requests the new address
        @(posedge clk_i);
        if (!fetch_req.req) begin
            $display("no fetch request in the cycle after the redirect at %0t", $time);
            stop_run();
        end
        check_addr("fetch_req_o.addr", fetch_req.addr, exp_pc);
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic boot_sequence();
        // values seen here still belong to the last reset cycle
        if (fetch_req.req || entry_valid) begin
            $display("request or entry valid high during reset at %0t", $time);
            stop_run();
        end
        exp_pc = boot_addr;
        receive_entries(3);
    endtask

    // 0x108 jal to 0x148, forward branch at 0x14c, loop back at 0x150
    task automatic static_prediction();
        place_jal(32'h0000_0108, 32'h0000_0040);
        place_branch(32'h0000_014c, 32'h0000_0020);
        place_branch(32'h0000_0150, 32'hffff_fff0);
        redirect(1'b1, boot_addr, 1'b0, 1'b0);
        receive_entries(12);
    endtask

    task automatic back_pressure();
        redirect(1'b1, 32'h0000_0200, 1'b0, 1'b0);
        receive_random(40);
        receive_entries(4);
    endtask

    task automatic redirect_priority();
        // full queue of stale entries, then a mispredict
        entry_ready <= 1'b0;
        redirect(1'b1, 32'h0000_0300, 1'b0, 1'b0);
        idle(8);
        redirect(1'b1, 32'h0000_0400, 1'b0, 1'b0);
        receive_entries(4);
        // exception beats eret and mispredict
        entry_ready <= 1'b0;
        trap_vector <= 32'h0000_0500;
        epc         <= 32'h0000_0600;
        idle(6);
        redirect(1'b1, 32'h0000_0580, 1'b1, 1'b1);
        receive_entries(4);
        // eret beats mispredict
        entry_ready <= 1'b0;
        epc         <= 32'h0000_0680;
        idle(4);
        redirect(1'b1, 32'h0000_06c0, 1'b0, 1'b1);
        receive_entries(4);
    endtask

    task automatic fetch_fault();
        mark_fault(32'h0000_0708);
        redirect(1'b1, 32'h0000_0700, 1'b0, 1'b0);
        receive_entries(6);
    endtask

    initial begin
        rst_ni      <= 1'b0;
        flush       <= 1'b0;
        resolve     <= '0;
        ex_valid    <= 1'b0;
        trap_vector <= '0;
        eret        <= 1'b0;
        epc         <= '0;
        entry_ready <= 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        boot_sequence();
        static_prediction();
        back_pressure();
        redirect_priority();
        fetch_fault();

        $display("Test OK");
        $finish;
    end

endmodule

//--- source/fetch_frontend.sv
// single-issue RV32 fetch frontend, no compressed instructions
// memory must answer every request exactly one cycle later and never stall
// only static prediction: jal taken, backward branch taken, jalr never
// QueueDepth must be a power of two from 2 to 16
`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; #(
    parameter logic [XLEN-1:0] BootAddr   = 32'h0000_0100,
    parameter int unsigned     QueueDepth = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    // instruction memory
    output fetch_req_t      fetch_req_o,
    input  fetch_rsp_t      fetch_rsp_i,
    // redirect sources
    input  logic            flush_i,
    input  resolve_t        resolve_i,
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] trap_vector_i,
    input  logic            eret_i,
    input  logic [XLEN-1:0] epc_i,
    // towards decode
    output fetch_entry_t    fetch_entry_o,
    output logic            fetch_entry_valid_o,
    input  logic            fetch_entry_ready_i
);

    // controller strobes
    logic            req;
    logic            boot;
    logic            push;
    logic            replay;
    // pc generator
    logic [XLEN-1:0] fetch_addr;
    logic [XLEN-1:0] inflight_addr;
    logic            redirect;
    // scanner and queue
    cf_e             cf;
    scan_t           scan;
    fetch_entry_t    entry_in;
    logic            queue_full;
    logic [XLEN-1:0] replay_addr;

    // ------------------------------------------------------------
    // memory request
    // ------------------------------------------------------------
    assign fetch_req_o.req  = req;
    assign fetch_req_o.addr = fetch_addr;

    // response is tagged with the address requested last cycle
    assign entry_in.pc           = inflight_addr;
    assign entry_in.instr        = fetch_rsp_i.data;
    assign entry_in.fault        = fetch_rsp_i.fault;
    assign entry_in.cf           = cf;
    assign entry_in.predict_addr = scan.target;

    // drop level is only needed inside the controller
    fetch_ctrl i_fetch_ctrl (
        .clk_i        ( clk_i             ),
        .rst_ni       ( rst_ni            ),
        .rsp_valid_i  ( fetch_rsp_i.valid ),
        .redirect_i   ( redirect          ),
        .queue_full_i ( queue_full        ),
        .req_o        ( req               ),
        .boot_o       ( boot              ),
        .drop_rsp_o   (                   ),
        .push_o       ( push              ),
        .replay_o     ( replay            )
    );

    // prediction steers only when the response really enters the queue
    pc_gen #(
        .BootAddr ( BootAddr )
    ) i_pc_gen (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .boot_i          ( boot          ),
        .advance_i       ( push          ),
        .scan_i          ( scan          ),
        .replay_i        ( replay        ),
        .replay_addr_i   ( replay_addr   ),
        .resolve_i       ( resolve_i     ),
        .flush_i         ( flush_i       ),
        .ex_valid_i      ( ex_valid_i    ),
        .trap_vector_i   ( trap_vector_i ),
        .eret_i          ( eret_i        ),
        .epc_i           ( epc_i         ),
        .fetch_addr_o    ( fetch_addr    ),
        .inflight_addr_o ( inflight_addr ),
        .redirect_o      ( redirect      )
    );

    instr_scan i_instr_scan (
        .instr_i ( fetch_rsp_i.data  ),
        .pc_i    ( inflight_addr     ),
        .fault_i ( fetch_rsp_i.fault ),
        .cf_o    ( cf                ),
        .scan_o  ( scan              )
    );

    // any redirect empties the queue on the same edge
    fetch_queue #(
        .QueueDepth ( QueueDepth )
    ) i_fetch_queue (
        .clk_i         ( clk_i               ),
        .rst_ni        ( rst_ni              ),
        .flush_i       ( redirect            ),
        .push_i        ( push                ),
        .entry_i       ( entry_in            ),
        .ready_i       ( fetch_entry_ready_i ),
        .entry_o       ( fetch_entry_o       ),
        .valid_o       ( fetch_entry_valid_o ),
        .full_o        ( queue_full          ),
        .replay_addr_o ( replay_addr         )
    );

endmodule

//--- source/fetch_queue.sv
// queue of fetch entries towards decode
// circular buffer, QueueDepth a power of two from 2 to 16
// a push into a full queue is ignored, the controller replays it instead
// flush empties the queue, a pop in the same cycle has no effect
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; #(
    parameter int unsigned QueueDepth = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic            push_i,
    input  fetch_entry_t    entry_i,
    input  logic            ready_i,
    output fetch_entry_t    entry_o,
    output logic            valid_o,
    output logic            full_o,
    output logic [XLEN-1:0] replay_addr_o
);

    localparam int unsigned PtrW = $clog2(QueueDepth);

    // entry storage
    fetch_entry_t mem_q [QueueDepth];

    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW:0]   count_q;
    logic            write;
    logic            pop;

    // ------------------------------------------------------------
    // status
    // ------------------------------------------------------------
    assign valid_o = (count_q != '0);
    assign full_o  = (count_q == (PtrW + 1)'(QueueDepth));

    assign write = push_i & ~full_o & ~flush_i;
    assign pop   = valid_o & ready_i & ~flush_i;

    // head of the queue is always visible
    assign entry_o = mem_q[rd_ptr_q];

    // the word offered now is the one to fetch again when it is refused
    assign replay_addr_o = entry_i.pc;

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap by themselves, depth is a power of two
            if (write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keep the count
            case ({write, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage write
    always_ff @(posedge clk_i) begin
        if (write) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

//--- source/instr_scan.sv
// control-flow scanner for one 32-bit word, purely combinational
// jal predicted taken, branch taken only with a negative offset
// jalr is marked but never predicted, a faulting word is never control flow
`timescale 1ns/1ps

module instr_scan import fetch_pkg::*; (
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            fault_i,
    output cf_e             cf_o,
    output scan_t           scan_o
);

    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic            branch_taken;

    // ------------------------------------------------------------
    // classify
    // ------------------------------------------------------------
    // opcode is at the same place in both views
    assign is_branch = ~fault_i & (instr_i.btype.opcode == OpBranch);
    assign is_jal    = ~fault_i & (instr_i.jtype.opcode == OpJal);
    assign is_jalr   = ~fault_i & (instr_i.btype.opcode == OpJalr);

    // ------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------
    // b-type, 13 bit offset
    assign b_imm = {{19{instr_i.btype.imm12}},
                    instr_i.btype.imm12,
                    instr_i.btype.imm11,
                    instr_i.btype.imm10_5,
                    instr_i.btype.imm4_1,
                    1'b0};

    // j-type, 21 bit offset
    assign j_imm = {{11{instr_i.jtype.imm20}},
                    instr_i.jtype.imm20,
                    instr_i.jtype.imm19_12,
                    instr_i.jtype.imm11,
                    instr_i.jtype.imm10_1,
                    1'b0};

    // backward branches are loops, assume taken
    assign branch_taken = is_branch & b_imm[XLEN-1];

    // ------------------------------------------------------------
    // prediction
    // ------------------------------------------------------------
    always_comb begin
        cf_o          = CF_NONE;
        scan_o.taken  = 1'b0;
        // not taken means the next word
        scan_o.target = pc_i + XLEN'(4);
        if (is_jal) begin
            cf_o          = CF_JUMP;
            scan_o.taken  = 1'b1;
            scan_o.target = pc_i + j_imm;
        end else if (branch_taken) begin
            cf_o          = CF_BRANCH;
            scan_o.taken  = 1'b1;
            scan_o.target = pc_i + b_imm;
        end else if (is_jalr) begin
            // target unknown here, fetch continues sequentially
            cf_o = CF_JUMPR;
        end
    end

endmodule

//--- source/pc_gen.sv
// next-PC generation
// fetch address is npc, or the predicted target of an accepted response
// priority: boot, exception, eret, mispredict, flush, replay, sequential
// flush restarts at the in-flight address plus 4
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
    parameter logic [XLEN-1:0] BootAddr = '0
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            boot_i,
    input  logic            advance_i,
    input  scan_t           scan_i,
    input  logic            replay_i,
    input  logic [XLEN-1:0] replay_addr_i,
    input  resolve_t        resolve_i,
    input  logic            flush_i,
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] trap_vector_i,
    input  logic            eret_i,
    input  logic [XLEN-1:0] epc_i,
    output logic [XLEN-1:0] fetch_addr_o,
    output logic [XLEN-1:0] inflight_addr_o,
    output logic            redirect_o
);

    logic [XLEN-1:0] npc_d, npc_q;
    logic [XLEN-1:0] inflight_d, inflight_q;
    logic            mispredict;

    assign mispredict = resolve_i.valid & resolve_i.mispredict;

    // depends on the redirect inputs only, keeps the controller loop-free
    assign redirect_o = ex_valid_i | eret_i | mispredict | flush_i;

    // predicted target goes out in the same cycle as the response
    assign fetch_addr_o    = (advance_i && scan_i.taken) ? scan_i.target : npc_q;
    assign inflight_addr_o = inflight_q;

    // ------------------------------------------------------------
    // next-PC select, later assignments win
    // ------------------------------------------------------------
    always_comb begin
        // default is the word after the one requested now
        npc_d      = {fetch_addr_o[XLEN-1:2], 2'b00} + XLEN'(4);
        inflight_d = fetch_addr_o;
        // nothing was requested, so the in-flight tag stays on the dropped word
        if (replay_i) begin
            npc_d      = replay_addr_i;
            inflight_d = inflight_q;
        end
        if (flush_i) begin
            npc_d = inflight_q + XLEN'(4);
        end
        if (mispredict) begin
            npc_d = resolve_i.target;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        // exception beats everything else
        if (ex_valid_i) begin
            npc_d = trap_vector_i;
        end
        if (boot_i) begin
            npc_d = BootAddr;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q <= '0;
        end else begin
            npc_q <= npc_d;
        end
    end

    // tag of the outstanding request
    always_ff @(posedge clk_i) begin
        inflight_q <= inflight_d;
    end

endmodule

//--- source/fetch_ctrl.sv
// fetch controller FSM
// one kill bit: the response after a redirect cycle is dropped (FLUSHED)
// a response that meets a full queue is replayed, never lost
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic rsp_valid_i,
    input  logic redirect_i,
    input  logic queue_full_i,
    output logic req_o,
    output logic boot_o,
    output logic drop_rsp_o,
    output logic push_o,
    output logic replay_o
);

    typedef enum logic [1:0] {
        BOOT    = 2'd0,
        RUN     = 2'd1,
        STALL   = 2'd2,
        FLUSHED = 2'd3
    } state_e;

    state_e state_d, state_q;
    logic   accept;

    // ------------------------------------------------------------
    // response handling
    // ------------------------------------------------------------
    // the redirect cycle and the cycle after it carry stale responses
    assign drop_rsp_o = redirect_i | (state_q == FLUSHED);
    assign accept     = rsp_valid_i & ~drop_rsp_o;
    assign push_o     = accept & ~queue_full_i;
    // keep reloading the replay address for the whole stall
    assign replay_o   = (accept & queue_full_i) | (state_q == STALL);

    // no request while booting or while a replay is pending
    assign req_o  = (state_q != BOOT) & ~replay_o;
    assign boot_o = (state_q == BOOT);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            BOOT: begin
                state_d = RUN;
            end
            RUN: begin
                if (redirect_i) begin
                    state_d = FLUSHED;
                end else if (accept && queue_full_i) begin
                    state_d = STALL;
                end
            end
            STALL: begin
                // resume one cycle after space returns
                if (redirect_i) begin
                    state_d = FLUSHED;
                end else if (!queue_full_i) begin
                    state_d = RUN;
                end
            end
            FLUSHED: begin
                if (!redirect_i) begin
                    state_d = RUN;
                end
            end
            default: begin
                state_d = BOOT;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= BOOT;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- source/fetch_pkg.sv
// shared types of the RV32 fetch frontend
// only uncompressed 32-bit instructions are handled
// memory word and address share one width (XLEN)
package fetch_pkg;

    // address and instruction width
    localparam int unsigned XLEN = 32;

    // major opcodes the scanner looks for
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;

    // control-flow kind carried with every queue entry
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2,
        CF_JUMPR  = 2'd3
    } cf_e;

    // ------------------------------------------------------------
    // instruction word views
    // ------------------------------------------------------------
    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } btype_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jtype_t;

    // one 32-bit word, opcode sits at [6:0] in both views
    typedef union packed {
        btype_t btype;
        jtype_t jtype;
    } instr_u;

    // ------------------------------------------------------------
    // port bundles
    // ------------------------------------------------------------
    // request towards instruction memory
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } fetch_req_t;

    // memory answer, one cycle after the request
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] data;
        logic            fault;
    } fetch_rsp_t;

    // branch resolution from the backend
    typedef struct packed {
        logic            valid;
        logic            mispredict;
        logic [XLEN-1:0] target;
    } resolve_t;

    // entry handed to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            fault;
        cf_e             cf;
        logic [XLEN-1:0] predict_addr;
    } fetch_entry_t;

    // static prediction of the scanned word
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } scan_t;

endpackage
